// File: source/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

////////////////////
// Field widths
////////////////////

// Instruction and data path.
`define MIPS_INSTR_W 32
`define MIPS_REG_ADDR_W 5
`define MIPS_IMM_W 16
`define MIPS_INDEX_W 26
`define MIPS_OPCODE_W 6
`define MIPS_FUNCT_W 6

// Stop instruction.
`define MIPS_HALT_WORD 32'hFFFF_FFFF

////////////////////
// Flow control
////////////////////

`define MIPS_QUEUE_DEPTH 4
`define MIPS_STAGE_CREDITS 2
`define MIPS_OUT_CREDITS 4

`endif

// File: source/mips_pkg.sv
`include "mips_defs.svh"

package mips_pkg;

    // Operation class seen by the later stages.
    typedef enum logic [3:0]
    {
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_RTYPE,
        OP_JR,
        OP_JALR,
        OP_BEQ,
        OP_BNE,
        OP_J,
        OP_JAL,
        OP_ITYPE,
        OP_HALT
    } op_e;

    typedef struct packed
    {
        logic [`MIPS_INSTR_W-1:0] instruction;
        logic [`MIPS_INSTR_W-1:0] pc;
    } fetch_t;

    typedef struct packed
    {
        op_e                         op;
        logic [`MIPS_REG_ADDR_W-1:0] reg_a;     // Rs.
        logic [`MIPS_REG_ADDR_W-1:0] reg_b;     // Rt.
        logic [`MIPS_REG_ADDR_W-1:0] reg_w;
        logic [`MIPS_IMM_W-1:0]      imm;       // Shamt for shifts.
        logic [`MIPS_INDEX_W-1:0]    index;
        logic [`MIPS_INSTR_W-1:0]    pc;
    } decode_t;

endpackage

// File: source/pipe_if.sv
`timescale 1ns/1ps

////////////////////
// Queue to decoder
////////////////////

interface fetch_if;
    logic              valid;
    mips_pkg::fetch_t  payload;
    logic              credit;     // One pulse per retired entry.

    modport producer
    (
        output valid,
        output payload,
        input  credit
    );

    modport consumer
    (
        input  valid,
        input  payload,
        output credit
    );
endinterface

////////////////////
// Decoder to operands
////////////////////

interface decode_if;
    logic               valid;
    mips_pkg::decode_t  payload;
    logic               credit;

    modport producer
    (
        output valid,
        output payload,
        input  credit
    );

    modport consumer
    (
        input  valid,
        input  payload,
        output credit
    );
endinterface

// File: source/instr_queue.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module instr_queue
(
    input  logic                      i_clock,
    input  logic                      i_rst,
    input  logic                      i_in_valid,
    input  logic [`MIPS_INSTR_W-1:0]  i_instruction,
    input  logic [`MIPS_INSTR_W-1:0]  i_pc,
    output logic                      o_in_credit,
    fetch_if.producer                 o_fetch
);

    localparam int PTR_W = $clog2(`MIPS_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`MIPS_QUEUE_DEPTH + 1);
    localparam int CRD_W = $clog2(`MIPS_STAGE_CREDITS + 1);

    mips_pkg::fetch_t   entry_q [`MIPS_QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic [CRD_W-1:0]   credit_cnt;
    logic               pop;

    assign pop = (count != '0) && (credit_cnt != '0); // Head leaves only with decoder credit.

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge i_clock)
    begin
        if (i_in_valid)
        begin
            entry_q[wr_ptr].instruction <= i_instruction;
            entry_q[wr_ptr].pc          <= i_pc;
        end
        if (pop)
        begin
            o_fetch.payload <= entry_q[rd_ptr];
        end
    end

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_cnt    <= CRD_W'(`MIPS_STAGE_CREDITS);
            o_fetch.valid <= 1'b0;
            o_in_credit   <= 1'b0;
        end
        else
        begin
            if (i_in_valid)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count         <= count + CNT_W'(i_in_valid) - CNT_W'(pop);
            credit_cnt    <= credit_cnt - CRD_W'(pop) + CRD_W'(o_fetch.credit);
            o_fetch.valid <= pop;
            o_in_credit   <= pop; // Slot freed, caller may push again.
        end
    end

    // The caller only pushes while it holds one of the credits this queue hands out.
    a_no_push_full: assert property (@(posedge i_clock) disable iff (i_rst)
        i_in_valid |-> (count != CNT_W'(`MIPS_QUEUE_DEPTH)));

endmodule

// File: source/decoder.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module decoder
(
    input  logic        i_clock,
    input  logic        i_rst,
    fetch_if.consumer   i_fetch,
    decode_if.producer  o_decode,
    output logic        o_halted
);

    localparam int DEPTH  = `MIPS_STAGE_CREDITS;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int RS_LSB = `MIPS_IMM_W + `MIPS_REG_ADDR_W;
    localparam int RT_LSB = `MIPS_IMM_W;
    localparam int RD_LSB = `MIPS_IMM_W - `MIPS_REG_ADDR_W;
    localparam int SH_LSB = `MIPS_FUNCT_W;

    localparam logic [`MIPS_OPCODE_W-1:0] OPC_SPECIAL = 6'd0;
    localparam logic [`MIPS_OPCODE_W-1:0] OPC_J       = 6'd2;
    localparam logic [`MIPS_OPCODE_W-1:0] OPC_JAL     = 6'd3;
    localparam logic [`MIPS_OPCODE_W-1:0] OPC_BEQ     = 6'd4;
    localparam logic [`MIPS_OPCODE_W-1:0] OPC_BNE     = 6'd5;
    localparam logic [`MIPS_FUNCT_W-1:0]  FN_SLL      = 6'd0;
    localparam logic [`MIPS_FUNCT_W-1:0]  FN_SRL      = 6'd2;
    localparam logic [`MIPS_FUNCT_W-1:0]  FN_SRA      = 6'd3;
    localparam logic [`MIPS_FUNCT_W-1:0]  FN_JR       = 6'd8;
    localparam logic [`MIPS_FUNCT_W-1:0]  FN_JALR     = 6'd9;

    logic [`MIPS_INSTR_W-1:0]   instr;
    logic [`MIPS_OPCODE_W-1:0]  opcode;
    logic [`MIPS_FUNCT_W-1:0]   funct;
    mips_pkg::decode_t          dec;
    mips_pkg::decode_t          entry_q [DEPTH];
    logic [DEPTH-1:0]           kill_q;     // Arrived after halt.
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           count;
    logic [CNT_W-1:0]           credit_cnt;
    mips_pkg::decode_t          head;
    logic                       head_vld;
    logic                       head_kill;
    logic                       send;
    logic                       pop;
    logic                       halt_sent;  // Halt has left toward operands.

    always_comb
    begin
        instr     = i_fetch.payload.instruction;
        opcode    = instr[`MIPS_INSTR_W-1 -: `MIPS_OPCODE_W];
        funct     = instr[`MIPS_FUNCT_W-1:0];
        dec.reg_a = instr[RS_LSB +: `MIPS_REG_ADDR_W];
        dec.reg_b = instr[RT_LSB +: `MIPS_REG_ADDR_W];
        dec.reg_w = instr[RD_LSB +: `MIPS_REG_ADDR_W];
        dec.imm   = instr[`MIPS_IMM_W-1:0];
        dec.index = instr[`MIPS_INDEX_W-1:0];
        dec.pc    = i_fetch.payload.pc;
        dec.op    = mips_pkg::OP_ITYPE;
        if (instr == `MIPS_HALT_WORD)
        begin
            dec.op = mips_pkg::OP_HALT;
        end
        else if (opcode == OPC_SPECIAL)
        begin
            case (funct)
                FN_SLL:  dec.op = mips_pkg::OP_SLL;
                FN_SRL:  dec.op = mips_pkg::OP_SRL;
                FN_SRA:  dec.op = mips_pkg::OP_SRA;
                FN_JR:   dec.op = mips_pkg::OP_JR;
                FN_JALR: dec.op = mips_pkg::OP_JALR;
                default: dec.op = mips_pkg::OP_RTYPE;
            endcase
            if (dec.op inside {mips_pkg::OP_SLL, mips_pkg::OP_SRL, mips_pkg::OP_SRA})
            begin
                dec.imm = {{(`MIPS_IMM_W - `MIPS_REG_ADDR_W){1'b0}},
                           instr[SH_LSB +: `MIPS_REG_ADDR_W]}; // Shamt.
            end
        end
        else
        begin
            case (opcode)
                OPC_BEQ: dec.op = mips_pkg::OP_BEQ;
                OPC_BNE: dec.op = mips_pkg::OP_BNE;
                OPC_J:   dec.op = mips_pkg::OP_J;
                OPC_JAL:
                begin
                    dec.op    = mips_pkg::OP_JAL;
                    dec.reg_w = '1; // Link register.
                end
                default: dec.op = mips_pkg::OP_ITYPE;
            endcase
        end
    end

    ////////////////////
    // Hand-off
    ////////////////////

    always_comb
    begin
        head_vld  = (count != '0) || i_fetch.valid;
        head      = (count != '0) ? entry_q[rd_ptr] : dec; // Empty buffer passes straight on.
        head_kill = (count != '0) ? kill_q[rd_ptr] : o_halted;
        send      = head_vld && !head_kill && (credit_cnt != '0);
        pop       = send || (head_vld && head_kill);
    end

    always_ff @(posedge i_clock)
    begin
        if (i_fetch.valid && ((count != '0) || !pop))
        begin
            entry_q[wr_ptr] <= dec;
            kill_q[wr_ptr]  <= o_halted;
        end
        if (send)
        begin
            o_decode.payload <= head;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            credit_cnt     <= CNT_W'(`MIPS_STAGE_CREDITS);
            o_decode.valid <= 1'b0;
            i_fetch.credit <= 1'b0;
            o_halted       <= 1'b0;
            halt_sent      <= 1'b0;
        end
        else
        begin
            if (i_fetch.valid && ((count != '0) || !pop))
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && (count != '0))
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count          <= count + CNT_W'(i_fetch.valid) - CNT_W'(pop);
            credit_cnt     <= credit_cnt - CNT_W'(send) + CNT_W'(o_decode.credit);
            o_decode.valid <= send;
            i_fetch.credit <= pop; // Dropped items still give their credit back.
            if (i_fetch.valid && (dec.op == mips_pkg::OP_HALT))
            begin
                o_halted <= 1'b1;
            end
            if (send && (head.op == mips_pkg::OP_HALT))
            begin
                halt_sent <= 1'b1;
            end
        end
    end

    // Operand stage never returns more credits than it was given.
    a_credit_max: assert property (@(posedge i_clock) disable iff (i_rst)
        credit_cnt <= CNT_W'(`MIPS_STAGE_CREDITS));

    // Nothing follows the halt out of the decoder.
    a_halt_last: assert property (@(posedge i_clock) disable iff (i_rst)
        halt_sent |-> !send);

endmodule

// File: source/operand_stage.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module operand_stage
(
    input  logic                         i_clock,
    input  logic                         i_rst,
    decode_if.consumer                   i_decode,
    input  logic                         i_wb_en,
    input  logic [`MIPS_REG_ADDR_W-1:0]  i_wb_addr,
    input  logic [`MIPS_INSTR_W-1:0]     i_wb_data,
    input  logic                         i_out_credit,
    output logic                         o_out_valid,
    output mips_pkg::op_e                o_op,
    output logic [`MIPS_REG_ADDR_W-1:0]  o_reg_w,
    output logic [`MIPS_INSTR_W-1:0]     o_data_a,
    output logic [`MIPS_INSTR_W-1:0]     o_data_b,
    output logic [`MIPS_INSTR_W-1:0]     o_imm_ext,
    output logic [`MIPS_INSTR_W-1:0]     o_target,
    output logic                         o_taken
);

    localparam int W     = `MIPS_INSTR_W;
    localparam int DEPTH = `MIPS_STAGE_CREDITS;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int OCR_W = $clog2(`MIPS_OUT_CREDITS + 1);

    logic [W-1:0]       rf_q [2 ** `MIPS_REG_ADDR_W];
    mips_pkg::decode_t  entry_q [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic [OCR_W-1:0]   out_cnt;
    logic [OCR_W-1:0]   in_flight;  // Results not yet credited back.
    mips_pkg::decode_t  head;
    logic               head_vld;
    logic               send;
    logic [W-1:0]       data_a;
    logic [W-1:0]       data_b;
    logic [W-1:0]       imm_ext;
    logic [W-1:0]       pc_next;
    logic [W-1:0]       target;
    logic               taken;

    function automatic logic [W-1:0] read_reg(input logic [`MIPS_REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        else if (i_wb_en && (i_wb_addr == addr))
            return i_wb_data; // Same-cycle write wins.
        else
            return rf_q[addr];
    endfunction

    always_ff @(posedge i_clock)
    begin
        if (i_wb_en)
        begin
            rf_q[i_wb_addr] <= i_wb_data;
        end
    end

    ////////////////////
    // Operands, target
    ////////////////////

    always_comb
    begin
        head_vld = (count != '0) || i_decode.valid;
        head     = (count != '0) ? entry_q[rd_ptr] : i_decode.payload;
        send     = head_vld && (out_cnt != '0);
        data_a   = read_reg(head.reg_a);
        data_b   = read_reg(head.reg_b);
        if (head.op inside {mips_pkg::OP_SLL, mips_pkg::OP_SRL, mips_pkg::OP_SRA})
            imm_ext = {{(W - `MIPS_IMM_W){1'b0}}, head.imm};
        else
            imm_ext = {{(W - `MIPS_IMM_W){head.imm[`MIPS_IMM_W-1]}}, head.imm};
        pc_next = head.pc + 32'd4;
        target  = '0;
        taken   = 1'b0;
        case (head.op)
            mips_pkg::OP_BEQ:
            begin
                target = pc_next + (imm_ext << 2);
                taken  = (data_a == data_b);
            end
            mips_pkg::OP_BNE:
            begin
                target = pc_next + (imm_ext << 2);
                taken  = (data_a != data_b);
            end
            mips_pkg::OP_J, mips_pkg::OP_JAL:
            begin
                target = {pc_next[W-1:`MIPS_INDEX_W+2], head.index, 2'b00}; // Region jump.
                taken  = 1'b1;
            end
            mips_pkg::OP_JR, mips_pkg::OP_JALR:
            begin
                target = data_a;
                taken  = 1'b1;
            end
            default: target = '0;
        endcase
    end

    always_ff @(posedge i_clock)
    begin
        if (i_decode.valid && ((count != '0) || !send))
        begin
            entry_q[wr_ptr] <= i_decode.payload;
        end
        if (send)
        begin
            o_op      <= head.op;
            o_reg_w   <= head.reg_w;
            o_data_a  <= data_a;
            o_data_b  <= data_b;
            o_imm_ext <= imm_ext;
            o_target  <= target;
            o_taken   <= taken;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            count           <= '0;
            out_cnt         <= OCR_W'(`MIPS_OUT_CREDITS);
            in_flight       <= '0;
            o_out_valid     <= 1'b0;
            i_decode.credit <= 1'b0;
        end
        else
        begin
            if (i_decode.valid && ((count != '0) || !send))
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send && (count != '0))
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count           <= count + CNT_W'(i_decode.valid) - CNT_W'(send);
            out_cnt         <= out_cnt - OCR_W'(send) + OCR_W'(i_out_credit);
            in_flight       <= in_flight + OCR_W'(o_out_valid) - OCR_W'(i_out_credit);
            o_out_valid     <= send;
            i_decode.credit <= send;
        end
    end

    // Port-level count of results the consumer still holds.
    a_valid_credit: assert property (@(posedge i_clock) disable iff (i_rst)
        o_out_valid |-> (in_flight < OCR_W'(`MIPS_OUT_CREDITS)));

    // Consumer returns at most what it received.
    a_out_credit_max: assert property (@(posedge i_clock) disable iff (i_rst)
        out_cnt <= OCR_W'(`MIPS_OUT_CREDITS));

endmodule

// File: source/mips_front.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_front
(
    input  logic                         i_clock,
    input  logic                         i_rst,
    input  logic                         i_in_valid,
    input  logic [`MIPS_INSTR_W-1:0]     i_instruction,
    input  logic [`MIPS_INSTR_W-1:0]     i_pc,
    output logic                         o_in_credit,
    input  logic                         i_wb_en,
    input  logic [`MIPS_REG_ADDR_W-1:0]  i_wb_addr,
    input  logic [`MIPS_INSTR_W-1:0]     i_wb_data,
    input  logic                         i_out_credit,
    output logic                         o_out_valid,
    output mips_pkg::op_e                o_op,
    output logic [`MIPS_REG_ADDR_W-1:0]  o_reg_w,
    output logic [`MIPS_INSTR_W-1:0]     o_data_a,
    output logic [`MIPS_INSTR_W-1:0]     o_data_b,
    output logic [`MIPS_INSTR_W-1:0]     o_imm_ext,
    output logic [`MIPS_INSTR_W-1:0]     o_target,
    output logic                         o_taken,
    output logic                         o_halted
);

    fetch_if  fetch_bus ();
    decode_if decode_bus ();

    ////////////////////
    // Stages
    ////////////////////

    instr_queue u_queue
    (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_in_valid    (i_in_valid),
        .i_instruction (i_instruction),
        .i_pc          (i_pc),
        .o_in_credit   (o_in_credit),
        .o_fetch       (fetch_bus.producer)
    );

    decoder u_decoder
    (
        .i_clock  (i_clock),
        .i_rst    (i_rst),
        .i_fetch  (fetch_bus.consumer),
        .o_decode (decode_bus.producer),
        .o_halted (o_halted)
    );

    operand_stage u_operand
    (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_decode     (decode_bus.consumer),
        .i_wb_en      (i_wb_en),
        .i_wb_addr    (i_wb_addr),
        .i_wb_data    (i_wb_data),
        .i_out_credit (i_out_credit),
        .o_out_valid  (o_out_valid),
        .o_op         (o_op),
        .o_reg_w      (o_reg_w),
        .o_data_a     (o_data_a),
        .o_data_b     (o_data_b),
        .o_imm_ext    (o_imm_ext),
        .o_target     (o_target),
        .o_taken      (o_taken)
    );

endmodule

// File: tests/tb_mips_front.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module tb_mips_front;

    typedef struct
    {
        mips_pkg::op_e  op;
        logic [4:0]     reg_w;
        logic [31:0]    data_a;
        logic [31:0]    data_b;
        logic [31:0]    imm_ext;
        logic [31:0]    target;
        logic           taken;
    } result_t;

    logic           clock;
    logic           rst;
    logic           in_valid;
    logic [31:0]    instruction;
    logic [31:0]    pc;
    logic           in_credit;
    logic           wb_en;
    logic [4:0]     wb_addr;
    logic [31:0]    wb_data;
    logic           out_credit;
    logic           out_valid;
    mips_pkg::op_e  op;
    logic [4:0]     reg_w;
    logic [31:0]    data_a;
    logic [31:0]    data_b;
    logic [31:0]    imm_ext;
    logic [31:0]    target;
    logic           taken;
    logic           halted;

    result_t        exp_q [$];
    int             errors;
    int             used;       // Inputs driven.
    int             returned;   // Input credits seen.
    int             pending;    // Output credits still owed.
    int             delay;
    integer         seed;

    mips_front dut
    (
        .i_clock (clock), .i_rst (rst), .i_in_valid (in_valid),
        .i_instruction (instruction), .i_pc (pc), .o_in_credit (in_credit),
        .i_wb_en (wb_en), .i_wb_addr (wb_addr), .i_wb_data (wb_data),
        .i_out_credit (out_credit), .o_out_valid (out_valid), .o_op (op),
        .o_reg_w (reg_w), .o_data_a (data_a), .o_data_b (data_b),
        .o_imm_ext (imm_ext), .o_target (target), .o_taken (taken),
        .o_halted (halted)
    );

    initial
    begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic check_op(input string name, input mips_pkg::op_e got,
                            input mips_pkg::op_e exp);
        if (got !== exp)
        begin
            $display("error at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    ////////////////////
    // Output side
    ////////////////////

    always @(posedge clock)
    begin
        result_t r;
        if (!rst)
        begin
            if (in_credit)
                returned++;
            if (out_valid)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("result at %0t arrived with no expected entry left", $time);
                    errors++;
                end
                else
                begin
                    r = exp_q.pop_front();
                    check_op("o_op", op, r.op);
                    check_word("o_reg_w", 32'(reg_w), 32'(r.reg_w));
                    check_word("o_data_a", data_a, r.data_a);
                    check_word("o_data_b", data_b, r.data_b);
                    check_word("o_imm_ext", imm_ext, r.imm_ext);
                    check_word("o_target", target, r.target);
                    check_bit("o_taken", taken, r.taken);
                end
            end
        end
    end

    // Consumer hands credits back after a random delay.
    always @(posedge clock)
    begin
        out_credit <= 1'b0;
        if (!rst)
        begin
            if (out_valid)
                pending++;
            if (pending > 0)
            begin
                if (delay == 0)
                begin
                    out_credit <= 1'b1;
                    pending--;
                    delay = $random(seed) & 3;
                end
                else
                    delay--;
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic push_instr(input logic [31:0] word, input logic [31:0] addr);
        int waited;
        waited = 0;
        @(posedge clock);
        while ((`MIPS_QUEUE_DEPTH + returned - used) <= 0 && waited < 100)
        begin
            in_valid <= 1'b0;
            waited++;
            @(posedge clock);
        end
        if (waited >= 100)
        begin
            $display("no input credit came back within 100 cycles");
            errors++;
            in_valid <= 1'b0;
        end
        else
        begin
            in_valid    <= 1'b1;
            instruction <= word;
            pc          <= addr;
            used++;
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clock);
        in_valid <= 1'b0;
        wb_en    <= 1'b1;
        wb_addr  <= addr;
        wb_data  <= data;
        @(posedge clock);
        wb_en    <= 1'b0;
    endtask

    // Lands in the cycle the last pushed word is read.
    task automatic write_in_read_cycle(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clock);
        in_valid <= 1'b0;
        @(posedge clock);
        write_reg(addr, data);
    endtask

    // Pipe must stay idle for a while, so late results still get caught.
    task automatic drain(output bit ok);
        int waited;
        int quiet;
        waited = 0;
        quiet = 0;
        @(posedge clock);
        in_valid <= 1'b0;
        while (quiet < 8 && waited < 300)
        begin
            if (exp_q.size() == 0 && returned == used && pending == 0 && !out_valid)
                quiet++;
            else
                quiet = 0;
            waited++;
            @(posedge clock);
        end
        ok = (quiet >= 8);
    endtask

    initial
    begin
        int         fd;
        int         n;
        int         err_start;
        int         tests;
        int         failed;
        bit         ok;
        reg [63:0]  kind;
        reg [127:0] name;
        reg [2047:0] line;
        logic [31:0] v [7];
        result_t    r;

        rst = 1'b1;
        in_valid = 1'b0;
        instruction = '0;
        pc = '0;
        wb_en = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        out_credit = 1'b0;
        errors = 0;
        used = 0;
        returned = 0;
        pending = 0;
        delay = 0;
        seed = 32'h1b2ef3d1;
        tests = 0;
        failed = 0;
        err_start = 0;
        repeat (5) @(posedge clock);
        rst <= 1'b0;

        fd = $fopen("tests/front_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open tests/front_trace.txt");
            $display("Result: FAILED");
            $finish;
        end
        else
        begin
            while ($fscanf(fd, "%s", kind) == 1)
            begin
                if (kind == "#")
                    n = $fgets(line, fd);
                else if (kind == "W")
                begin
                    n = $fscanf(fd, "%h %h", v[0], v[1]);
                    write_reg(v[0][4:0], v[1]);
                end
                else if (kind == "B")
                begin
                    n = $fscanf(fd, "%h %h", v[0], v[1]);
                    write_in_read_cycle(v[0][4:0], v[1]);
                end
                else if (kind == "I")
                begin
                    n = $fscanf(fd, "%h %h", v[0], v[1]);
                    push_instr(v[0], v[1]);
                end
                else if (kind == "E")
                begin
                    n = $fscanf(fd, "%h %h %h %h %h %h %h", v[0], v[1], v[2], v[3],
                                v[4], v[5], v[6]);
                    r.op = mips_pkg::op_e'(v[0][3:0]);
                    r.reg_w = v[1][4:0];
                    r.data_a = v[2];
                    r.data_b = v[3];
                    r.imm_ext = v[4];
                    r.target = v[5];
                    r.taken = v[6][0];
                    exp_q.push_back(r);
                end
                else if (kind == "T")
                begin
                    n = $fscanf(fd, "%s %h", name, v[0]);
                    drain(ok);
                    if (!ok)
                    begin
                        $display("outputs or credits did not settle within 300 cycles");
                        errors++;
                    end
                    check_bit("o_halted", halted, v[0][0]);
                    tests++;
                    if (errors != err_start)
                        failed++;
                    $display("test %0s: %0s", name, (errors == err_start) ? "ok" : "failed");
                    err_start = errors;
                end
                else
                begin
                    $display("unknown trace line kind %0s", kind);
                    errors++;
                end
            end
            $fclose(fd);
            $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
            if (errors == 0 && tests > 0)
                $display("Result: PASSED");
            else
                $display("Result: FAILED");
            $finish;
        end
    end

    initial
    begin
        #3000000;
        $display("simulation ran past its time limit");
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: tests/front_trace.txt
# W addr data | I word pc | B addr data, written in the read cycle of the last I
# E op reg_w data_a data_b imm_ext target taken | T name halted
W 08 80000010
W 09 000000f0
I 00085100 00000100
E 0 0a 00000000 80000010 00000004 00000000 0
I 00095fc2 00000104
E 1 0b 00000000 000000f0 0000001f 00000000 0
I 01286043 00000108
E 2 0c 000000f0 80000010 00000001 00000000 0
T shifts 0
W 01 00000005
W 02 00000005
W 03 00000007
I 10220010 00000200
E 6 00 00000005 00000005 00000010 00000244 1
I 1023fffe 00000300
E 6 1f 00000005 00000007 fffffffe 000002fc 0
I 14230008 00000400
E 7 00 00000005 00000007 00000008 00000424 1
I 14228000 00000500
E 7 10 00000005 00000005 ffff8000 fffe0504 0
T branches 0
W 04 00400020
W 05 12345678
I 08000040 10000000
E 8 00 00000000 00000000 00000040 10000100 1
I 0c001234 f0000000
E 9 1f 00000000 00000000 00001234 f00048d0 1
I 00800008 00000600
E 4 00 00400020 00000000 00000008 00400020 1
I 00a0f809 00000604
E 5 1f 12345678 00000000 fffff809 12345678 1
T jumps 0
I 00233020 00000700
E 3 06 00000005 00000007 00003020 00000000 0
I 2044ffff 00000704
E a 1f 00000005 00400020 ffffffff 00000000 0
I 8c650004 00000708
E a 00 00000007 12345678 00000004 00000000 0
I 00853825 0000070c
E 3 07 00400020 12345678 00003825 00000000 0
I 10840001 00000710
E 6 00 00400020 00400020 00000001 00000718 1
I 00000000 00000714
E 0 00 00000000 00000000 00000000 00000000 0
T burst 0
W 00 deadbeef
W 0d 11111111
I 000d7021 00000800
E 3 0e 00000000 22222222 00007021 00000000 0
B 0d 22222222
I 01a00820 00000804
E 3 01 22222222 00000000 00000820 00000000 0
T regzero 0
W 1f 31313131
I ffffffff 00000900
E b 1f 31313131 31313131 ffffffff 00000000 0
I 00233020 00000904
I 2044ffff 00000908
T halt 1

// File: project.f
+incdir+source
source/mips_pkg.sv
source/pipe_if.sv
source/instr_queue.sv
source/decoder.sv
source/operand_stage.sv
source/mips_front.sv
tests/tb_mips_front.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the front-end testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_mips_front -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
    exit 0
else
    exit 1
fi
